// ==== hdl/exu_pkg.sv ====
// RV64 only; loads, stores and branches have no encodings here and decode as invalid
package exu_pkg;

  localparam int XLEN    = 64;
  localparam int INST_WD = 32;

  // major opcodes handled by the decoder
  localparam logic [6:0] OP        = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_32     = 7'b0111011;
  localparam logic [6:0] OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] LUI       = 7'b0110111;
  localparam logic [6:0] AUIPC     = 7'b0010111;
  localparam logic [6:0] JAL       = 7'b1101111;
  localparam logic [6:0] JALR      = 7'b1100111;
  localparam logic [6:0] SYSTEM    = 7'b1110011;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // immediate csr forms share these codes
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3
  } csr_op_e;

  typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;

  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
  } rv_inst_u;

endpackage

// ==== hdl/exu_ctrl_if.sv ====
// one decoded item per cycle; valid qualifies all other fields, there is no handshake
`timescale 1ns/1ps

interface exu_ctrl_if;
  import exu_pkg::*;

  logic            valid;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] csr_rdata;
  src_a_e          src_a_sel;
  src_b_e          src_b_sel;
  alu_op_e         alu_op;
  logic            word_cut;
  csr_op_e         csr_op;
  logic            csr_use_imm;
  logic            ebreak;
  logic            invalid;

  modport producer (
    output valid, rs1_data, rs2_data, imm, pc, csr_rdata,
    output src_a_sel, src_b_sel, alu_op, word_cut, csr_op, csr_use_imm, ebreak, invalid
  );

  modport consumer (
    input valid, rs1_data, rs2_data, imm, pc, csr_rdata,
    input src_a_sel, src_b_sel, alu_op, word_cut, csr_op, csr_use_imm, ebreak, invalid
  );

endinterface

// ==== hdl/inst_decoder.sv ====
// purely combinational; ecall, loads, stores, branches and fences are flagged invalid
`timescale 1ns/1ps

module inst_decoder (
  input  logic                      i_valid,
  input  exu_pkg::rv_inst_u         i_inst,
  input  logic [exu_pkg::XLEN-1:0]  i_pc,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1_data,
  input  logic [exu_pkg::XLEN-1:0]  i_rs2_data,
  input  logic [exu_pkg::XLEN-1:0]  i_csr_rdata,
  exu_ctrl_if.producer              o_ctrl
);
  import exu_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] zimm;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            bad;
  csr_op_e         csr_op;

  function automatic alu_op_e f3_to_alu(input logic [2:0] fn3, input logic alt);
    alu_op_e op;
    case (fn3)
      3'd0:    op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign f3 = i_inst.i.funct3;
  assign f7 = i_inst.r.funct7;

  assign imm_i = {{(XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  // csr immediate sits in the rs1 field
  assign zimm  = {{(XLEN-5){1'b0}}, i_inst.i.rs1};

  assign o_ctrl.valid     = i_valid;
  assign o_ctrl.pc        = i_pc;
  assign o_ctrl.rs1_data  = i_rs1_data;
  assign o_ctrl.rs2_data  = i_rs2_data;
  assign o_ctrl.csr_rdata = i_csr_rdata;

  always_comb begin
    o_ctrl.imm         = imm_i;
    o_ctrl.src_a_sel   = SRC_A_RS1;
    o_ctrl.src_b_sel   = SRC_B_RS2;
    o_ctrl.alu_op      = ALU_ADD;
    o_ctrl.word_cut    = 1'b0;
    o_ctrl.csr_use_imm = 1'b0;
    o_ctrl.ebreak      = 1'b0;
    csr_op             = CSR_NONE;
    bad                = 1'b0;
    case (i_inst.r.opcode)
      OP: begin
        o_ctrl.alu_op = f3_to_alu(f3, f7[5]);
        bad = !(f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      OP_IMM: begin
        o_ctrl.src_b_sel = SRC_B_IMM;
        o_ctrl.alu_op    = f3_to_alu(f3, f3 == 3'd5 && f7[5]);
        // rv64 shamt is six bits, so only funct7[6:1] is fixed
        if (f3 == 3'd1)
          bad = f7[6:1] != 6'b0;
        else if (f3 == 3'd5)
          bad = !(f7[6:1] == 6'b0 || f7[6:1] == 6'b010000);
      end
      OP_32: begin
        o_ctrl.word_cut = 1'b1;
        o_ctrl.alu_op   = f3_to_alu(f3, f7[5]);
        bad = !((f7 == 7'b0 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
                (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5)));
      end
      OP_IMM_32: begin
        o_ctrl.word_cut  = 1'b1;
        o_ctrl.src_b_sel = SRC_B_IMM;
        o_ctrl.alu_op    = f3_to_alu(f3, f3 == 3'd5 && f7[5]);
        bad = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'b0) ||
                (f3 == 3'd5 && (f7 == 7'b0 || f7 == 7'b0100000)));
      end
      LUI: begin
        o_ctrl.imm       = imm_u;
        o_ctrl.src_b_sel = SRC_B_IMM;
        o_ctrl.alu_op    = ALU_PASS_B;
      end
      AUIPC: begin
        o_ctrl.imm       = imm_u;
        o_ctrl.src_a_sel = SRC_A_PC;
        o_ctrl.src_b_sel = SRC_B_IMM;
      end
      JAL, JALR: begin
        // link value only; target is computed outside this slice
        o_ctrl.imm       = (i_inst.r.opcode == JAL) ? imm_j : imm_i;
        o_ctrl.src_a_sel = SRC_A_PC;
        o_ctrl.src_b_sel = SRC_B_FOUR;
        bad = (i_inst.r.opcode == JALR) && (f3 != 3'd0);
      end
      SYSTEM: begin
        o_ctrl.imm         = zimm;
        o_ctrl.src_b_sel   = SRC_B_IMM;
        o_ctrl.alu_op      = ALU_PASS_B;
        o_ctrl.csr_use_imm = f3[2];
        if (f3[1:0] == 2'b00) begin
          o_ctrl.ebreak = (f3 == 3'd0) && (i_inst.i.imm12 == 12'd1);
          bad = !o_ctrl.ebreak;
        end else begin
          csr_op = csr_op_e'({1'b0, f3[1:0]});
        end
      end
      default: bad = 1'b1;
    endcase
    o_ctrl.invalid = bad;
    o_ctrl.csr_op  = bad ? CSR_NONE : csr_op;
  end

endmodule

// ==== hdl/id_ex_buffer.sv ====
// one-entry stage, loads on every edge; only valid is reset, fields are don't-care while low
`timescale 1ns/1ps

module id_ex_buffer (
  input  logic          i_clk,
  input  logic          i_arst_n,
  exu_ctrl_if.consumer  i_ctrl,
  exu_ctrl_if.producer  o_ctrl
);
  import exu_pkg::*;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ctrl.valid <= 1'b0;
    end else begin
      o_ctrl.valid <= i_ctrl.valid;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    o_ctrl.rs1_data    <= i_ctrl.rs1_data;
    o_ctrl.rs2_data    <= i_ctrl.rs2_data;
    o_ctrl.imm         <= i_ctrl.imm;
    o_ctrl.pc          <= i_ctrl.pc;
    o_ctrl.csr_rdata   <= i_ctrl.csr_rdata;
    o_ctrl.src_a_sel   <= i_ctrl.src_a_sel;
    o_ctrl.src_b_sel   <= i_ctrl.src_b_sel;
    o_ctrl.alu_op      <= i_ctrl.alu_op;
    o_ctrl.word_cut    <= i_ctrl.word_cut;
    o_ctrl.csr_op      <= i_ctrl.csr_op;
    o_ctrl.csr_use_imm <= i_ctrl.csr_use_imm;
    o_ctrl.ebreak      <= i_ctrl.ebreak;
    o_ctrl.invalid     <= i_ctrl.invalid;
  end

endmodule

// ==== hdl/alu.sv ====
// expects word-op sources already zero-extended from 32 bits; slt/sltu are not word ops
`timescale 1ns/1ps

module alu (
  input  logic [exu_pkg::XLEN-1:0]  i_src_a,
  input  logic [exu_pkg::XLEN-1:0]  i_src_b,
  input  exu_pkg::alu_op_e          i_alu_op,
  input  logic                      i_word_cut,
  output logic [exu_pkg::XLEN-1:0]  o_result
);
  import exu_pkg::*;

  logic [5:0]      shamt;
  logic [31:0]     sra_w;
  logic [XLEN-1:0] res;

  // word shifts use five bits of shift amount
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];
  assign sra_w = $signed(i_src_a[31:0]) >>> shamt[4:0];

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    res = i_src_a + i_src_b;
      ALU_SUB:    res = i_src_a - i_src_b;
      ALU_SLL:    res = i_src_a << shamt;
      ALU_SLT:    res = {{(XLEN-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b)};
      ALU_SLTU:   res = {{(XLEN-1){1'b0}}, i_src_a < i_src_b};
      ALU_XOR:    res = i_src_a ^ i_src_b;
      ALU_SRL:    res = i_src_a >> shamt;
      ALU_SRA: begin
        if (i_word_cut)
          res = {{(XLEN-32){1'b0}}, sra_w};
        else
          res = $signed(i_src_a) >>> shamt;
      end
      ALU_OR:     res = i_src_a | i_src_b;
      ALU_AND:    res = i_src_a & i_src_b;
      ALU_PASS_B: res = i_src_b;
      default:    res = '0;
    endcase
  end

  // w forms return the low word sign-extended
  assign o_result = i_word_cut ? {{(XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

// ==== hdl/csr_unit.sv ====
// computes the write value only; csr address, privilege and read-only checks are not done
`timescale 1ns/1ps

module csr_unit (
  input  logic [exu_pkg::XLEN-1:0]  i_csr_rdata,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1_data,
  input  logic [exu_pkg::XLEN-1:0]  i_zimm,
  input  exu_pkg::csr_op_e          i_csr_op,
  input  logic                      i_use_imm,
  output logic [exu_pkg::XLEN-1:0]  o_csr_wdata
);
  import exu_pkg::*;

  logic [XLEN-1:0] src;

  assign src = i_use_imm ? i_zimm : i_rs1_data;

  always_comb begin
    case (i_csr_op)
      CSR_RW:  o_csr_wdata = src;
      CSR_RS:  o_csr_wdata = i_csr_rdata | src;
      CSR_RC:  o_csr_wdata = i_csr_rdata & ~src;
      // no write, old value passes through
      default: o_csr_wdata = i_csr_rdata;
    endcase
  end

endmodule

// ==== hdl/exec_unit.sv ====
// one-cycle execute; flags and csr write are qualified by valid, results register every edge
`timescale 1ns/1ps

module exec_unit (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  exu_ctrl_if.consumer              i_ctrl,
  output logic                      o_valid,
  output logic                      o_csr_write,
  output logic                      o_ebreak,
  output logic                      o_invalid,
  output logic [exu_pkg::XLEN-1:0]  o_alu_result,
  output logic [exu_pkg::XLEN-1:0]  o_csr_result
);
  import exu_pkg::*;

  logic [XLEN-1:0] rs1_cut;
  logic [XLEN-1:0] rs2_cut;
  logic [XLEN-1:0] imm_cut;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] csr_res;

  // word ops see zero-extended low words
  assign rs1_cut = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_ctrl.rs1_data[31:0]} : i_ctrl.rs1_data;
  assign rs2_cut = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_ctrl.rs2_data[31:0]} : i_ctrl.rs2_data;
  assign imm_cut = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_ctrl.imm[31:0]} : i_ctrl.imm;

  assign src_a = (i_ctrl.src_a_sel == SRC_A_PC) ? i_ctrl.pc : rs1_cut;

  always_comb begin
    case (i_ctrl.src_b_sel)
      SRC_B_RS2:  src_b = rs2_cut;
      SRC_B_IMM:  src_b = imm_cut;
      SRC_B_FOUR: src_b = XLEN'(4);
      default:    src_b = '0;
    endcase
  end

  alu u_alu (
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_alu_op   (i_ctrl.alu_op),
    .i_word_cut (i_ctrl.word_cut),
    .o_result   (alu_res)
  );

  csr_unit u_csr_unit (
    .i_csr_rdata (i_ctrl.csr_rdata),
    .i_rs1_data  (i_ctrl.rs1_data),
    .i_zimm      (i_ctrl.imm),
    .i_csr_op    (i_ctrl.csr_op),
    .i_use_imm   (i_ctrl.csr_use_imm),
    .o_csr_wdata (csr_res)
  );

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid      <= 1'b0;
      o_csr_write  <= 1'b0;
      o_ebreak     <= 1'b0;
      o_invalid    <= 1'b0;
      o_alu_result <= '0;
      o_csr_result <= '0;
    end else begin
      o_valid      <= i_ctrl.valid;
      o_csr_write  <= i_ctrl.valid && (i_ctrl.csr_op != CSR_NONE);
      o_ebreak     <= i_ctrl.valid && i_ctrl.ebreak;
      o_invalid    <= i_ctrl.valid && i_ctrl.invalid;
      o_alu_result <= alu_res;
      o_csr_result <= csr_res;
    end
  end

endmodule

// ==== hdl/exu_top.sv ====
// fixed two-cycle latency, one item per cycle, no stall; outputs are meaningful only with o_valid
`timescale 1ns/1ps

module exu_top (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_valid,
  input  logic [exu_pkg::INST_WD-1:0]  i_inst,
  input  logic [exu_pkg::XLEN-1:0]     i_pc,
  input  logic [exu_pkg::XLEN-1:0]     i_rs1_data,
  input  logic [exu_pkg::XLEN-1:0]     i_rs2_data,
  input  logic [exu_pkg::XLEN-1:0]     i_csr_rdata,
  output logic                         o_valid,
  output logic [exu_pkg::XLEN-1:0]     o_alu_result,
  output logic [exu_pkg::XLEN-1:0]     o_csr_result,
  output logic                         o_csr_write,
  output logic                         o_ebreak,
  output logic                         o_invalid
);

  exu_ctrl_if dec_if ();
  exu_ctrl_if ex_if ();

  inst_decoder u_inst_decoder (
    .i_valid     (i_valid),
    .i_inst      (i_inst),
    .i_pc        (i_pc),
    .i_rs1_data  (i_rs1_data),
    .i_rs2_data  (i_rs2_data),
    .i_csr_rdata (i_csr_rdata),
    .o_ctrl      (dec_if.producer)
  );

  id_ex_buffer u_id_ex_buffer (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ctrl   (dec_if.consumer),
    .o_ctrl   (ex_if.producer)
  );

  exec_unit u_exec_unit (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_ctrl       (ex_if.consumer),
    .o_valid      (o_valid),
    .o_csr_write  (o_csr_write),
    .o_ebreak     (o_ebreak),
    .o_invalid    (o_invalid),
    .o_alu_result (o_alu_result),
    .o_csr_result (o_csr_result)
  );

endmodule

// ==== verif/tb_exu_top.sv ====
// run from the project root so verif/exu_golden.txt is found; vectors issue back to back
`timescale 1ns/1ps

module tb_exu_top;

  localparam int MAX_VEC      = 64;
  localparam int RESET_CYCLES = 2;

  logic        clk;
  logic        i_arst_n;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] i_rs1_data;
  logic [63:0] i_rs2_data;
  logic [63:0] i_csr_rdata;
  logic        o_valid;
  logic [63:0] o_alu_result;
  logic [63:0] o_csr_result;
  logic        o_csr_write;
  logic        o_ebreak;
  logic        o_invalid;

  // one row per golden line, columns as in the file
  logic [63:0] vec [MAX_VEC][10];
  int          issue_cyc [MAX_VEC];

  int n_vec     = 0;
  int n_issued  = 0;
  int n_checked = 0;
  int n_pass    = 0;
  int n_fail    = 0;
  int errors    = 0;
  int cycles    = 0;
  int limit     = 0;
  bit test_bad;

  exu_top u_dut (
    .i_clk        (clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .i_rs1_data   (i_rs1_data),
    .i_rs2_data   (i_rs2_data),
    .i_csr_rdata  (i_csr_rdata),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_csr_result (o_csr_result),
    .o_csr_write  (o_csr_write),
    .o_ebreak     (o_ebreak),
    .o_invalid    (o_invalid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("verif/exu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/exu_golden.txt for reading");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          if (n_vec >= MAX_VEC) begin
            $display("too many vectors in golden file, line ignored: %s", line);
            errors++;
          end else begin
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                          vec[n_vec][0], vec[n_vec][1], vec[n_vec][2], vec[n_vec][3],
                          vec[n_vec][4], vec[n_vec][5], vec[n_vec][6], vec[n_vec][7],
                          vec[n_vec][8], vec[n_vec][9]);
            if (cnt != 10) begin
              $display("malformed line in golden file: %s", line);
              errors++;
            end else begin
              n_vec++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_field(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      test_bad = 1'b1;
    end
  endtask

  task automatic check_reset_state();
    test_bad = 1'b0;
    compare_field("reset o_valid", 64'(o_valid), 64'd0);
    compare_field("reset o_csr_write", 64'(o_csr_write), 64'd0);
    compare_field("reset o_ebreak", 64'(o_ebreak), 64'd0);
    compare_field("reset o_invalid", 64'(o_invalid), 64'd0);
    compare_field("reset o_alu_result", o_alu_result, 64'd0);
    compare_field("reset o_csr_result", o_csr_result, 64'd0);
    if (test_bad) begin
      n_fail++;
      $display("test 0 (reset state): failed");
    end else begin
      n_pass++;
      $display("test 0 (reset state): ok");
    end
  endtask

  task automatic drive_vector(input int idx);
    i_valid        = 1'b1;
    i_inst         = vec[idx][0][31:0];
    i_pc           = vec[idx][1];
    i_rs1_data     = vec[idx][2];
    i_rs2_data     = vec[idx][3];
    i_csr_rdata    = vec[idx][4];
    issue_cyc[idx] = cycles;
    n_issued       = idx + 1;
  endtask

  task automatic check_result(input int idx);
    int num;
    num      = idx + 1;
    test_bad = 1'b0;
    if (cycles - issue_cyc[idx] != 2) begin
      $display("FAILED at %0t: test %0d came out after %0d cycles instead of 2",
               $time, num, cycles - issue_cyc[idx]);
      test_bad = 1'b1;
    end
    // alu result carries meaning only for alu ops
    if (!(vec[idx][7][0] || vec[idx][8][0] || vec[idx][9][0])) begin
      compare_field($sformatf("test %0d alu result", num), o_alu_result, vec[idx][5]);
    end
    compare_field($sformatf("test %0d csr result", num), o_csr_result, vec[idx][6]);
    compare_field($sformatf("test %0d csr_write", num), 64'(o_csr_write), vec[idx][7]);
    compare_field($sformatf("test %0d ebreak", num), 64'(o_ebreak), vec[idx][8]);
    compare_field($sformatf("test %0d invalid", num), 64'(o_invalid), vec[idx][9]);
    if (test_bad) begin
      n_fail++;
      $display("test %0d (inst %h): failed", num, vec[idx][0][31:0]);
    end else begin
      n_pass++;
      $display("test %0d (inst %h): ok", num, vec[idx][0][31:0]);
    end
  endtask

  // outputs settle at the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (i_arst_n && o_valid) begin
      if (n_checked >= n_issued) begin
        $display("o_valid went high at %0t with no vector outstanding", $time);
        errors++;
      end else begin
        check_result(n_checked);
        n_checked++;
      end
    end
  end

  initial begin
    int k;
    clk         = 1'b0;
    i_arst_n    = 1'b0;
    i_valid     = 1'b0;
    i_inst      = '0;
    i_pc        = '0;
    i_rs1_data  = '0;
    i_rs2_data  = '0;
    i_csr_rdata = '0;
    load_vectors();
    limit = n_vec + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(negedge clk);
    i_arst_n = 1'b1;
    check_reset_state();
    if (errors == 0) begin
      for (k = 0; k < n_vec; k++) begin
        drive_vector(k);
        @(negedge clk);
      end
      i_valid = 1'b0;
    end
    while (n_checked < n_vec && cycles < limit) begin
      @(negedge clk);
    end
    if (n_checked < n_vec) begin
      $display("timeout after %0d cycles: %0d of %0d results never came out with o_valid high",
               cycles, n_vec - n_checked, n_vec);
      errors++;
    end
    $display("%0d tests passed, %0d tests failed, %0d other errors", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0 && n_vec > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verif/exu_golden.txt ====
# inst pc rs1 rs2 csr_rdata | expected: alu_result csr_result csr_write ebreak invalid (all hex)
# alu_result is only compared on lines with csr_write, ebreak and invalid all zero
002081b3 1000 ffffffff 1 0 100000000 0 0 0 0
402081b3 1000 5 7 0 fffffffffffffffe 0 0 0 0
002091b3 1000 1 7f 0 8000000000000000 0 0 0 0
0020a1b3 1000 ffffffffffffffff 1 0 1 0 0 0 0
0020b1b3 1000 ffffffffffffffff 1 0 0 0 0 0 0
0020c1b3 1000 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 f0f0f0f0f0f0f0f0 0 0 0 0
0020d1b3 1000 8000000000000000 4 0 0800000000000000 0 0 0 0
4020d1b3 1000 8000000000000000 4 0 f800000000000000 0 0 0 0
0020e1b3 1000 12340000 5678 5a5a 12345678 5a5a 0 0 0
0020f1b3 1000 123456789abcdef0 0000ffff0000ffff 0 000056780000def0 0 0 0 0
fff08193 1000 0 1234 0 ffffffffffffffff 0 0 0 0
002081bb 1000 123456787fffffff 1 0 ffffffff80000000 0 0 0 0
402081bb 1000 ffffffff00000001 2 0 ffffffffffffffff 0 0 0 0
002091bb 1000 ffff000000000003 3f 0 ffffffff80000000 0 0 0 0
0020d1bb 1000 ffffffff80000000 4 0 0000000008000000 0 0 0 0
4020d1bb 1000 abcd000080000000 4 0 fffffffff8000000 0 0 0 0
ffe0819b 1000 0000000100000001 0 0 ffffffffffffffff 0 0 0 0
abcde1b7 1000 0 0 0 ffffffffabcde000 0 0 0 0
fffff197 80000000 0 0 0 7ffff000 0 0 0 0
008000ef 1000 0 0 0 1004 0 0 0 0
000280e7 fffffffffffffffc 55 0 0 0 0 0 0 0
300091f3 1000 88 0 1800 0 88 1 0 0
3000a1f3 1000 f 0 f0 0 ff 1 0 0
3000b1f3 1000 f 0 ff 0 f0 1 0 0
300fd1f3 1000 1234 0 ffff000000000000 0 1f 1 0 0
3002e1f3 1000 ffffffffffffffff 0 8000000000000000 0 8000000000000005 1 0 0
3001f1f3 1000 ffffffffffffffff 0 ff 0 fc 1 0 0
00100073 1000 0 0 55 0 55 0 1 0
0000a183 1000 0 0 aa 0 aa 0 0 1

// ==== files.f ====
hdl/exu_pkg.sv
hdl/exu_ctrl_if.sv
hdl/inst_decoder.sv
hdl/id_ex_buffer.sv
hdl/alu.sv
hdl/csr_unit.sv
hdl/exec_unit.sv
hdl/exu_top.sv
verif/tb_exu_top.sv

// ==== run.sh ====
#!/bin/sh
# builds with Verilator and runs from the project root; exit status follows the testbench result
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_exu_top \
  -o tb_exu_top \
  && ./obj_dir/tb_exu_top > sim.log 2>&1 ; cat sim.log 2>/dev/null ; \
  grep -qx "Testbench passed" sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
